//--- build.f
+incdir+include
src/zynq_shell_pkg.sv
src/dram_req_if.sv
src/host_csr_regs.sv
src/gp1_addr_translate.sv
src/dram_addr_remap.sv
src/mem_profiler.sv
src/zynq_shell_top.sv
sim/zynq_shell_checker.sv
sim/tb_zynq_shell.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_zynq_shell
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test completed successfully" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/tb_zynq_shell.sv
`timescale 1ns/10ps
`default_nettype none

`include "zynq_shell_defines.svh"

module tb_zynq_shell;

   localparam int WAIT_LIMIT = 200;

   logic                         aclk = 1'b0;
   logic                         rst_i;
   logic                         csr_req_valid_i;
   logic                         csr_req_ready_o;
   logic                         csr_we_i;
   zynq_shell_pkg::zs_csr_idx_t  csr_idx_i;
   zynq_shell_pkg::zs_word_t     csr_wdata_i;
   logic                         csr_rsp_valid_o;
   logic                         csr_rsp_ready_i;
   zynq_shell_pkg::zs_word_t     csr_rdata_o;
   zynq_shell_pkg::zs_resp_e     csr_resp_o;
   logic                         gp1_valid_i;
   logic                         gp1_ready_o;
   zynq_shell_pkg::zs_gp1_addr_t gp1_addr_i;
   logic                         gp1_we_i;
   logic                         bp_valid_o;
   logic                         bp_ready_i;
   zynq_shell_pkg::zs_addr_t     bp_addr_o;
   logic                         bp_we_o;
   logic                         bp_host_sel_o;
   logic                         acc_valid_i;
   logic                         acc_ready_o;
   zynq_shell_pkg::zs_addr_t     acc_addr_i;
   logic                         acc_we_i;
   logic                         ps_valid_o;
   logic                         ps_ready_i;
   zynq_shell_pkg::zs_addr_t     ps_addr_o;
   logic                         ps_we_o;
   logic                         accel_rst_o;

   // reference model state
   zynq_shell_pkg::zs_addr_t     base_m;
   zynq_shell_pkg::zs_prof_map_t prof_m;
   logic [1:0]                   err_m;
   int                           tb_errors;
   int                           i;
   zynq_shell_pkg::zs_gp1_addr_t ga;
   zynq_shell_pkg::zs_addr_t     aa;

   zynq_shell_top uut (.*);

   zynq_shell_checker chk (
      .aclk            (aclk),
      .rst_i           (rst_i),
      .csr_req_valid_i (csr_req_valid_i),
      .csr_req_ready_i (csr_req_ready_o),
      .csr_rsp_valid_i (csr_rsp_valid_o),
      .csr_rsp_ready_i (csr_rsp_ready_i),
      .csr_rdata_i     (csr_rdata_o),
      .csr_resp_i      (csr_resp_o),
      .bp_valid_i      (bp_valid_o),
      .bp_ready_i      (bp_ready_i),
      .bp_addr_i       (bp_addr_o),
      .bp_we_i         (bp_we_o),
      .bp_host_sel_i   (bp_host_sel_o),
      .ps_valid_i      (ps_valid_o),
      .ps_ready_i      (ps_ready_i),
      .ps_addr_i       (ps_addr_o),
      .ps_we_i         (ps_we_o)
   );

   always #50 aclk = ~aclk;

   // gp1 window address to {host_sel, accelerator address}
   // the upper half of the window maps to zero and the lower half to the dram base
   function automatic logic [32:0] gp1_expect(input zynq_shell_pkg::zs_gp1_addr_t a);
      zynq_shell_pkg::zs_addr_t x;
      logic                     host;
      x    = (a[29] ? 32'h0000_0000 : `ZS_DRAM_BASE) + {4'h0, a[27:0]};
      host = a[29] && ({4'h0, a[27:0]} < `ZS_HOST_SPLIT);
      return {host, x};
   endfunction

   // accelerator address to {out of range, processor address}
   function automatic logic [32:0] remap_expect(input zynq_shell_pkg::zs_addr_t a,
                                                input zynq_shell_pkg::zs_addr_t base);
      zynq_shell_pkg::zs_addr_t off;
      off = a ^ `ZS_DRAM_BASE;
      return {(off >= `ZS_MEM_LIMIT), off + base};
   endfunction

   function automatic zynq_shell_pkg::zs_prof_map_t prof_expect(
      input zynq_shell_pkg::zs_prof_map_t map, input zynq_shell_pkg::zs_addr_t a);
      zynq_shell_pkg::zs_prof_map_t one;
      one = 1;
      return map | (one << a[`ZS_PROF_IDX_HI -: 7]);
   endfunction

   task automatic give_up(input string what);
      $display("timeout: %s", what);
      $display("Test failed");
      $finish;
   endtask

   task automatic report_and_finish();
      $display("errors: checker %0d, testbench %0d", chk.err_count, tb_errors);
      if (chk.err_count == 0 && tb_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   endtask

   task automatic expect_bit(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
         tb_errors++;
      end
   endtask

   // path 0 is the register port, 1 the gp1 input, 2 the accelerator input
   task automatic wait_accept(input int path, input string what);
      int   cnt;
      logic hit;
      cnt = 0;
      hit = 1'b0;
      while (!hit && cnt < WAIT_LIMIT) begin
         @(negedge aclk);
         case (path)
            0:       hit = csr_req_ready_o;
            1:       hit = gp1_ready_o;
            default: hit = acc_ready_o;
         endcase
         cnt++;
      end
      if (!hit) begin
         give_up(what);
      end else begin
         @(posedge aclk);
         #1;
         case (path)
            0:       csr_req_valid_i = 1'b0;
            1:       gp1_valid_i = 1'b0;
            default: acc_valid_i = 1'b0;
         endcase
      end
   endtask

   task automatic csr_access(input logic we, input zynq_shell_pkg::zs_csr_idx_t idx,
                             input zynq_shell_pkg::zs_word_t wdata,
                             input zynq_shell_pkg::zs_word_t exp_data,
                             input zynq_shell_pkg::zs_resp_e exp_resp,
                             input logic chk_data);
      chk.expect_rsp({chk_data, exp_resp, exp_data});
      csr_we_i        = we;
      csr_idx_i       = idx;
      csr_wdata_i     = wdata;
      csr_req_valid_i = 1'b1;
      wait_accept(0, "host register request never accepted");
   endtask

   task automatic csr_read(input zynq_shell_pkg::zs_csr_idx_t idx,
                           input zynq_shell_pkg::zs_word_t exp);
      csr_access(1'b0, idx, '0, exp, zynq_shell_pkg::ZS_RESP_OKAY, 1'b1);
   endtask

   // only indices 0 to 2 are writable
   task automatic csr_write(input zynq_shell_pkg::zs_csr_idx_t idx,
                            input zynq_shell_pkg::zs_word_t data);
      zynq_shell_pkg::zs_resp_e resp;
      resp = (idx <= `ZS_CSR_DRAM_BASE) ? zynq_shell_pkg::ZS_RESP_OKAY
                                        : zynq_shell_pkg::ZS_RESP_SLVERR;
      if (idx == `ZS_CSR_DRAM_BASE) begin
         base_m = data;
      end
      csr_access(1'b1, idx, data, '0, resp, 1'b0);
   endtask

   task automatic send_gp1(input zynq_shell_pkg::zs_gp1_addr_t a, input logic we);
      chk.expect_bp({we, gp1_expect(a)});
      gp1_addr_i  = a;
      gp1_we_i    = we;
      gp1_valid_i = 1'b1;
      wait_accept(1, "gp1 request never accepted");
   endtask

   task automatic send_acc(input zynq_shell_pkg::zs_addr_t a, input logic we);
      logic [32:0] exp;
      exp = remap_expect(a, base_m);
      chk.expect_ps({we, exp[31:0]});
      if (exp[32]) begin
         if (we) begin
            err_m[0] = 1'b1;
         end else begin
            err_m[1] = 1'b1;
         end
      end
      prof_m      = prof_expect(prof_m, a);
      acc_addr_i  = a;
      acc_we_i    = we;
      acc_valid_i = 1'b1;
      wait_accept(2, "accelerator dram request never accepted");
   endtask

   task automatic drain_and_report();
      int cnt;
      cnt = 0;
      while (chk.pending() != 0 && cnt < WAIT_LIMIT) begin
         @(negedge aclk);
         cnt++;
      end
      if (chk.pending() != 0) begin
         give_up("expected outputs still outstanding at the end of the run");
      end else begin
         report_and_finish();
      end
   endtask

   // random back-pressure on every output path
   initial begin
      bp_ready_i      = 1'b0;
      ps_ready_i      = 1'b0;
      csr_rsp_ready_i = 1'b0;
      forever begin
         @(posedge aclk);
         #1;
         bp_ready_i      = ($urandom % 4) != 0;
         ps_ready_i      = ($urandom % 3) != 0;
         csr_rsp_ready_i = ($urandom % 4) != 0;
      end
   end

   initial begin
      void'($urandom(2766));
      rst_i           = 1'b1;
      csr_req_valid_i = 1'b0;
      csr_we_i        = 1'b0;
      csr_idx_i       = '0;
      csr_wdata_i     = '0;
      gp1_valid_i     = 1'b0;
      gp1_addr_i      = '0;
      gp1_we_i        = 1'b0;
      acc_valid_i     = 1'b0;
      acc_addr_i      = '0;
      acc_we_i        = 1'b0;
      base_m          = '0;
      prof_m          = '0;
      err_m           = 2'b00;
      tb_errors       = 0;
      repeat (5) @(posedge aclk);
      #1;
      rst_i = 1'b0;

      // state after reset
      @(negedge aclk);
      expect_bit("accel_rst_o", accel_rst_o, 1'b1);
      expect_bit("bp_valid_o", bp_valid_o, 1'b0);
      expect_bit("ps_valid_o", ps_valid_o, 1'b0);
      expect_bit("csr_rsp_valid_o", csr_rsp_valid_o, 1'b0);
      @(posedge aclk);
      #1;
      csr_read(`ZS_CSR_RESET, 32'd1);
      for (i = 1; i < 8; i++) begin
         csr_read(3'(i), '0);
      end

      // writable registers then the read-only ones
      csr_write(`ZS_CSR_DRAM_ALLOC, 32'd1);
      csr_write(`ZS_CSR_DRAM_BASE, $urandom & 32'h3FF0_0000);
      csr_read(`ZS_CSR_DRAM_ALLOC, 32'd1);
      csr_read(`ZS_CSR_DRAM_BASE, base_m);
      for (i = 3; i < 8; i++) begin
         csr_write(3'(i), $urandom);
      end
      for (i = 3; i < 8; i++) begin
         csr_read(3'(i), '0);
      end
      // rejected writes leave the writable registers alone
      csr_read(`ZS_CSR_RESET, 32'd1);
      csr_read(`ZS_CSR_DRAM_ALLOC, 32'd1);
      csr_read(`ZS_CSR_DRAM_BASE, base_m);
      csr_write(`ZS_CSR_RESET, '0);
      csr_read(`ZS_CSR_RESET, '0);
      @(negedge aclk);
      expect_bit("accel_rst_o", accel_rst_o, 1'b0);
      @(posedge aclk);
      #1;

      // gp1 stream over both halves with every fourth one in host space
      for (i = 0; i < 40; i++) begin
         ga     = zynq_shell_pkg::zs_gp1_addr_t'($urandom);
         ga[29] = i[0];
         if (i % 4 == 1) begin
            ga[27:21] = '0;
         end
         send_gp1(ga, 1'($urandom));
      end

      // in-range accelerator dram traffic
      for (i = 0; i < 30; i++) begin
         aa = `ZS_DRAM_BASE | ($urandom % `ZS_MEM_LIMIT);
         send_acc(aa, 1'($urandom));
      end
      csr_read(`ZS_CSR_RANGE_ERR, {{(`ZS_DATA_W-2){1'b0}}, err_m});

      // one write and one read past the memory limit
      send_acc(32'h9000_0000 | ($urandom & 32'h0FFF_FFFF), 1'b1);
      csr_read(`ZS_CSR_RANGE_ERR, {{(`ZS_DATA_W-2){1'b0}}, err_m});
      send_acc($urandom & 32'h7FFF_FFFF, 1'b0);
      for (i = 0; i < 10; i++) begin
         aa = `ZS_DRAM_BASE | ($urandom % `ZS_MEM_LIMIT);
         send_acc(aa, 1'($urandom));
      end
      csr_read(`ZS_CSR_RANGE_ERR, {{(`ZS_DATA_W-2){1'b0}}, err_m});

      // profiler words before and after the soft reset clears them
      for (i = 4; i < 8; i++) begin
         csr_read(3'(i), prof_m[(i - 4) * `ZS_DATA_W +: `ZS_DATA_W]);
      end
      csr_write(`ZS_CSR_RESET, 32'd1);
      csr_write(`ZS_CSR_RESET, '0);
      prof_m = '0;
      for (i = 4; i < 8; i++) begin
         csr_read(3'(i), '0);
      end
      csr_read(`ZS_CSR_RANGE_ERR, {{(`ZS_DATA_W-2){1'b0}}, err_m});

      drain_and_report();
   end

endmodule

`default_nettype wire

//--- sim/zynq_shell_checker.sv
`timescale 1ns/10ps
`default_nettype none

// watches the output handshakes of zynq_shell_top and compares each
// transfer against the expectations queued by the testbench
module zynq_shell_checker (
   input wire logic                     aclk,
   input wire logic                     rst_i,
   input wire logic                     csr_req_valid_i,
   input wire logic                     csr_req_ready_i,
   input wire logic                     csr_rsp_valid_i,
   input wire logic                     csr_rsp_ready_i,
   input wire zynq_shell_pkg::zs_word_t csr_rdata_i,
   input wire zynq_shell_pkg::zs_resp_e csr_resp_i,
   input wire logic                     bp_valid_i,
   input wire logic                     bp_ready_i,
   input wire zynq_shell_pkg::zs_addr_t bp_addr_i,
   input wire logic                     bp_we_i,
   input wire logic                     bp_host_sel_i,
   input wire logic                     ps_valid_i,
   input wire logic                     ps_ready_i,
   input wire zynq_shell_pkg::zs_addr_t ps_addr_i,
   input wire logic                     ps_we_i
);

   // bp entry {we, host_sel, addr}, ps entry {we, addr}
   // rsp entry {compare data, resp, rdata}
   logic [33:0] bp_q[$];
   logic [32:0] ps_q[$];
   logic [34:0] rsp_q[$];
   logic        accepted_q = 1'b0;
   int          err_count = 0;

   task automatic expect_bp(input logic [33:0] e);
      bp_q.push_back(e);
   endtask

   task automatic expect_ps(input logic [32:0] e);
      ps_q.push_back(e);
   endtask

   task automatic expect_rsp(input logic [34:0] e);
      rsp_q.push_back(e);
   endtask

   function automatic int pending();
      return bp_q.size() + ps_q.size() + rsp_q.size();
   endfunction

   task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
         err_count++;
      end
   endtask

   task automatic report_extra(input string path);
      $display("error at %0t: transfer on %s with nothing expected", $time, path);
      err_count++;
   endtask

   // outputs and readies are steady at the falling edge, a transfer
   // seen here completes on the next rising edge
   always @(negedge aclk) begin
      logic [34:0] e;
      if (!rst_i) begin
         if (accepted_q && !csr_rsp_valid_i) begin
            $display("error at %0t: no host register response one cycle after acceptance",
                     $time);
            err_count++;
         end
         accepted_q = csr_req_valid_i && csr_req_ready_i;

         if (bp_valid_i && bp_ready_i) begin
            if (bp_q.size() == 0) begin
               report_extra("bp");
            end else begin
               e = {1'b0, bp_q.pop_front()};
               compare("bp_addr_o", e[31:0], bp_addr_i);
               compare("bp_host_sel_o", 32'(e[32]), 32'(bp_host_sel_i));
               compare("bp_we_o", 32'(e[33]), 32'(bp_we_i));
            end
         end

         if (ps_valid_i && ps_ready_i) begin
            if (ps_q.size() == 0) begin
               report_extra("ps");
            end else begin
               e = {2'b00, ps_q.pop_front()};
               compare("ps_addr_o", e[31:0], ps_addr_i);
               compare("ps_we_o", 32'(e[32]), 32'(ps_we_i));
            end
         end

         if (csr_rsp_valid_i && csr_rsp_ready_i) begin
            if (rsp_q.size() == 0) begin
               report_extra("csr response");
            end else begin
               e = rsp_q.pop_front();
               compare("csr_resp_o", 32'(e[33:32]), 32'(csr_resp_i));
               if (e[34]) begin
                  compare("csr_rdata_o", e[31:0], csr_rdata_i);
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- src/zynq_shell_top.sv
`timescale 1ns/10ps
`default_nettype none

module zynq_shell_top (
   input  wire logic                         aclk,
   input  wire logic                         rst_i,

   // host register port
   input  wire logic                         csr_req_valid_i,
   output logic                              csr_req_ready_o,
   input  wire logic                         csr_we_i,
   input  wire zynq_shell_pkg::zs_csr_idx_t  csr_idx_i,
   input  wire zynq_shell_pkg::zs_word_t     csr_wdata_i,
   output logic                              csr_rsp_valid_o,
   input  wire logic                         csr_rsp_ready_i,
   output zynq_shell_pkg::zs_word_t          csr_rdata_o,
   output zynq_shell_pkg::zs_resp_e          csr_resp_o,

   // processor gp1 window into the accelerator
   input  wire logic                         gp1_valid_i,
   output logic                              gp1_ready_o,
   input  wire zynq_shell_pkg::zs_gp1_addr_t gp1_addr_i,
   input  wire logic                         gp1_we_i,
   output logic                              bp_valid_o,
   input  wire logic                         bp_ready_i,
   output zynq_shell_pkg::zs_addr_t          bp_addr_o,
   output logic                              bp_we_o,
   output logic                              bp_host_sel_o,

   // accelerator dram requests out to processor dram
   input  wire logic                         acc_valid_i,
   output logic                              acc_ready_o,
   input  wire zynq_shell_pkg::zs_addr_t     acc_addr_i,
   input  wire logic                         acc_we_i,
   output logic                              ps_valid_o,
   input  wire logic                         ps_ready_i,
   output zynq_shell_pkg::zs_addr_t          ps_addr_o,
   output logic                              ps_we_o,

   output logic                              accel_rst_o
);

   logic [1:0]               range_err;
   logic [1:0]               prof_word_sel;
   zynq_shell_pkg::zs_word_t prof_word;
   zynq_shell_pkg::zs_addr_t dram_base;

   dram_req_if acc_req ();

   assign acc_req.valid = acc_valid_i;
   assign acc_req.addr  = acc_addr_i;
   assign acc_req.we    = acc_we_i;
   assign acc_ready_o   = acc_req.ready;

   // the allocated flag is only for host software to read back
   host_csr_regs u_csr (
      .aclk            (aclk),
      .rst_i           (rst_i),
      .csr_req_valid_i (csr_req_valid_i),
      .csr_req_ready_o (csr_req_ready_o),
      .csr_we_i        (csr_we_i),
      .csr_idx_i       (csr_idx_i),
      .csr_wdata_i     (csr_wdata_i),
      .csr_rsp_valid_o (csr_rsp_valid_o),
      .csr_rsp_ready_i (csr_rsp_ready_i),
      .csr_rdata_o     (csr_rdata_o),
      .csr_resp_o      (csr_resp_o),
      .range_err_i     (range_err),
      .prof_word_sel_o (prof_word_sel),
      .prof_word_i     (prof_word),
      .accel_rst_o     (accel_rst_o),
      .dram_alloc_o    (),
      .dram_base_o     (dram_base)
   );

   gp1_addr_translate u_gp1 (
      .aclk           (aclk),
      .rst_i          (rst_i),
      .in_valid_i     (gp1_valid_i),
      .in_ready_o     (gp1_ready_o),
      .in_addr_i      (gp1_addr_i),
      .in_we_i        (gp1_we_i),
      .out_valid_o    (bp_valid_o),
      .out_ready_i    (bp_ready_i),
      .out_addr_o     (bp_addr_o),
      .out_we_o       (bp_we_o),
      .out_host_sel_o (bp_host_sel_o)
   );

   dram_addr_remap u_remap (
      .aclk        (aclk),
      .rst_i       (rst_i),
      .req         (acc_req.dst),
      .dram_base_i (dram_base),
      .out_valid_o (ps_valid_o),
      .out_ready_i (ps_ready_i),
      .out_addr_o  (ps_addr_o),
      .out_we_o    (ps_we_o),
      .range_err_o (range_err)
   );

   mem_profiler u_prof (
      .aclk        (aclk),
      .accel_rst_i (accel_rst_o),
      .req         (acc_req.mon),
      .word_sel_i  (prof_word_sel),
      .word_o      (prof_word)
   );

endmodule

`default_nettype wire

//--- src/mem_profiler.sv
`timescale 1ns/10ps
`default_nettype none

`include "zynq_shell_defines.svh"

module mem_profiler (
   input  wire logic                 aclk,
   input  wire logic                 accel_rst_i,
   dram_req_if.mon                   req,
   input  wire logic [1:0]           word_sel_i,
   output zynq_shell_pkg::zs_word_t  word_o
);

   zynq_shell_pkg::zs_prof_map_t map_q;
   zynq_shell_pkg::zs_prof_idx_t region;
   logic                         req_fire;

   assign req_fire = req.valid && req.ready;

   // each region covers 8 MiB of the accelerator address space
   assign region = req.addr[`ZS_PROF_IDX_HI -: $bits(zynq_shell_pkg::zs_prof_idx_t)];

   // cleared for as long as the accelerator sits in reset
   always_ff @(posedge aclk) begin
      if (accel_rst_i) begin
         map_q <= '0;
      end else if (req_fire) begin
         map_q[region] <= 1'b1;
      end
   end

   // word 0 holds regions 0 to 31
   assign word_o = map_q[word_sel_i * `ZS_DATA_W +: `ZS_DATA_W];

endmodule

`default_nettype wire

//--- src/dram_addr_remap.sv
`timescale 1ns/10ps
`default_nettype none

`include "zynq_shell_defines.svh"

module dram_addr_remap (
   input  wire logic                     aclk,
   input  wire logic                     rst_i,
   dram_req_if.dst                       req,
   input  wire zynq_shell_pkg::zs_addr_t dram_base_i,
   output logic                          out_valid_o,
   input  wire logic                     out_ready_i,
   output zynq_shell_pkg::zs_addr_t      out_addr_o,
   output logic                          out_we_o,
   output logic [1:0]                    range_err_o
);

   zynq_shell_pkg::zs_stage_e stage_q;
   zynq_shell_pkg::zs_addr_t  offset;
   zynq_shell_pkg::zs_addr_t  rebased;
   logic [1:0]                err_q;
   logic                      in_fire;
   logic                      out_fire;
   logic                      too_high;

   // strip the accelerator dram base, then add the host-allocated base
   assign offset   = req.addr ^ `ZS_DRAM_BASE;
   assign rebased  = offset + dram_base_i;
   assign too_high = (offset >= `ZS_MEM_LIMIT);

   assign out_valid_o = (stage_q == zynq_shell_pkg::ZS_STAGE_FULL);
   assign out_fire    = out_valid_o && out_ready_i;
   assign req.ready   = (stage_q == zynq_shell_pkg::ZS_STAGE_EMPTY) || out_fire;
   assign in_fire     = req.valid && req.ready;

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         stage_q <= zynq_shell_pkg::ZS_STAGE_EMPTY;
      end else if (in_fire) begin
         stage_q <= zynq_shell_pkg::ZS_STAGE_FULL;
      end else if (out_fire) begin
         stage_q <= zynq_shell_pkg::ZS_STAGE_EMPTY;
      end
   end

   always_ff @(posedge aclk) begin
      if (in_fire) begin
         out_addr_o <= rebased;
         out_we_o   <= req.we;
      end
   end

   // sticky flags, bit 0 for writes and bit 1 for reads
   always_ff @(posedge aclk) begin
      if (rst_i) begin
         err_q <= 2'b00;
      end else if (in_fire && too_high) begin
         if (req.we) begin
            err_q[0] <= 1'b1;
         end else begin
            err_q[1] <= 1'b1;
         end
      end
   end

   assign range_err_o = err_q;

   // every output transfer is backed by an item taken in or held over
   fill_a: assert property (@(posedge aclk) disable iff (rst_i)
      out_valid_o && out_ready_i |-> $past(in_fire || (out_valid_o && !out_ready_i)))
      else $error("dram_addr_remap: output transfer from an empty stage");

endmodule

`default_nettype wire

//--- src/gp1_addr_translate.sv
`timescale 1ns/10ps
`default_nettype none

`include "zynq_shell_defines.svh"

module gp1_addr_translate (
   input  wire logic                         aclk,
   input  wire logic                         rst_i,
   input  wire logic                         in_valid_i,
   output logic                              in_ready_o,
   input  wire zynq_shell_pkg::zs_gp1_addr_t in_addr_i,
   input  wire logic                         in_we_i,
   output logic                              out_valid_o,
   input  wire logic                         out_ready_i,
   output zynq_shell_pkg::zs_addr_t          out_addr_o,
   output logic                              out_we_o,
   output logic                              out_host_sel_o
);

   zynq_shell_pkg::zs_stage_e stage_q;
   zynq_shell_pkg::zs_addr_t  xlat_addr;
   logic                      in_fire;
   logic                      out_fire;

   // upper half of the gp1 window maps to accelerator address zero,
   // lower half lands on the dram window at 0x8000_0000
   assign xlat_addr = {~in_addr_i[`ZS_GP1_ADDR_W-1], 3'b000, in_addr_i[27:0]};

   assign out_valid_o = (stage_q == zynq_shell_pkg::ZS_STAGE_FULL);
   assign out_fire    = out_valid_o && out_ready_i;
   assign in_ready_o  = (stage_q == zynq_shell_pkg::ZS_STAGE_EMPTY) || out_fire;
   assign in_fire     = in_valid_i && in_ready_o;

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         stage_q <= zynq_shell_pkg::ZS_STAGE_EMPTY;
      end else if (in_fire) begin
         stage_q <= zynq_shell_pkg::ZS_STAGE_FULL;
      end else if (out_fire) begin
         stage_q <= zynq_shell_pkg::ZS_STAGE_EMPTY;
      end
   end

   always_ff @(posedge aclk) begin
      if (in_fire) begin
         out_addr_o     <= xlat_addr;
         out_we_o       <= in_we_i;
         out_host_sel_o <= (xlat_addr < `ZS_HOST_SPLIT);
      end
   end

   // stalled item must not change under the consumer
   hold_a: assert property (@(posedge aclk) disable iff (rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_addr_o)
         && $stable(out_we_o) && $stable(out_host_sel_o))
      else $error("gp1_addr_translate: payload changed while stalled");

endmodule

`default_nettype wire

//--- src/host_csr_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "zynq_shell_defines.svh"

module host_csr_regs (
   input  wire logic                        aclk,
   input  wire logic                        rst_i,
   input  wire logic                        csr_req_valid_i,
   output logic                             csr_req_ready_o,
   input  wire logic                        csr_we_i,
   input  wire zynq_shell_pkg::zs_csr_idx_t csr_idx_i,
   input  wire zynq_shell_pkg::zs_word_t    csr_wdata_i,
   output logic                             csr_rsp_valid_o,
   input  wire logic                        csr_rsp_ready_i,
   output zynq_shell_pkg::zs_word_t         csr_rdata_o,
   output zynq_shell_pkg::zs_resp_e         csr_resp_o,
   input  wire logic [1:0]                  range_err_i,
   output logic [1:0]                       prof_word_sel_o,
   input  wire zynq_shell_pkg::zs_word_t    prof_word_i,
   output logic                             accel_rst_o,
   output logic                             dram_alloc_o,
   output zynq_shell_pkg::zs_addr_t         dram_base_o
);

   zynq_shell_pkg::zs_word_t    reset_q;
   zynq_shell_pkg::zs_word_t    alloc_q;
   zynq_shell_pkg::zs_addr_t    base_q;
   zynq_shell_pkg::zs_word_t    rd_word;
   zynq_shell_pkg::zs_csr_idx_t prof_off;
   logic                        rsp_valid_q;
   logic                        req_fire;

   // a new request may enter when the response slot frees up this cycle
   assign csr_req_ready_o = !rsp_valid_q || csr_rsp_ready_i;
   assign req_fire        = csr_req_valid_i && csr_req_ready_o;

   // profiler words sit at indices 4 to 7
   assign prof_off        = csr_idx_i - `ZS_CSR_PROF0;
   assign prof_word_sel_o = prof_off[1:0];

   always_comb begin
      case (csr_idx_i)
         `ZS_CSR_RESET:      rd_word = reset_q;
         `ZS_CSR_DRAM_ALLOC: rd_word = alloc_q;
         `ZS_CSR_DRAM_BASE:  rd_word = base_q;
         `ZS_CSR_RANGE_ERR:  rd_word = {{(`ZS_DATA_W-2){1'b0}}, range_err_i};
         default:            rd_word = prof_word_i;
      endcase
   end

   // writable registers, accelerator starts out held in reset
   always_ff @(posedge aclk) begin
      if (rst_i) begin
         reset_q <= 'd1;
         alloc_q <= '0;
         base_q  <= '0;
      end else if (req_fire && csr_we_i) begin
         case (csr_idx_i)
            `ZS_CSR_RESET:      reset_q <= csr_wdata_i;
            `ZS_CSR_DRAM_ALLOC: alloc_q <= csr_wdata_i;
            `ZS_CSR_DRAM_BASE:  base_q  <= csr_wdata_i;
            default:            ;
         endcase
      end
   end

   always_ff @(posedge aclk) begin
      if (rst_i) begin
         rsp_valid_q <= 1'b0;
      end else if (req_fire) begin
         rsp_valid_q <= 1'b1;
      end else if (csr_rsp_ready_i) begin
         rsp_valid_q <= 1'b0;
      end
   end

   // response payload, captured on acceptance
   always_ff @(posedge aclk) begin
      if (req_fire) begin
         csr_rdata_o <= csr_we_i ? '0 : rd_word;
         if (csr_we_i && (csr_idx_i > `ZS_CSR_DRAM_BASE)) begin
            csr_resp_o <= zynq_shell_pkg::ZS_RESP_SLVERR;
         end else begin
            csr_resp_o <= zynq_shell_pkg::ZS_RESP_OKAY;
         end
      end
   end

   assign csr_rsp_valid_o = rsp_valid_q;
   assign accel_rst_o     = rst_i || reset_q[0];
   assign dram_alloc_o    = alloc_q[0];
   assign dram_base_o     = base_q;

   // a pending response waits for the host
   rsp_hold_a: assert property (@(posedge aclk) disable iff (rst_i)
      csr_rsp_valid_o && !csr_rsp_ready_i |=> csr_rsp_valid_o)
      else $error("host_csr_regs: response dropped before it was taken");

endmodule

`default_nettype wire

//--- src/dram_req_if.sv
`timescale 1ns/10ps
`default_nettype none

// accelerator dram request, address and direction only
interface dram_req_if;

   logic                     valid;
   logic                     ready;
   zynq_shell_pkg::zs_addr_t addr;
   logic                     we;

   // the remap stage consumes requests
   modport dst (
      input  valid,
      input  addr,
      input  we,
      output ready
   );

   // observers see the whole handshake
   modport mon (
      input valid,
      input ready,
      input addr,
      input we
   );

endinterface

`default_nettype wire

//--- src/zynq_shell_pkg.sv
`default_nettype none

`include "zynq_shell_defines.svh"

package zynq_shell_pkg;

   typedef logic [`ZS_ADDR_W-1:0]     zs_addr_t;
   typedef logic [`ZS_GP1_ADDR_W-1:0] zs_gp1_addr_t;
   typedef logic [`ZS_DATA_W-1:0]     zs_word_t;
   typedef logic [`ZS_CSR_IDX_W-1:0]  zs_csr_idx_t;

   // one profiler bit per region
   typedef logic [$clog2(`ZS_PROF_REGIONS)-1:0] zs_prof_idx_t;
   typedef logic [`ZS_PROF_REGIONS-1:0]         zs_prof_map_t;

   // same coding as the axi resp field
   typedef enum logic [1:0] {
      ZS_RESP_OKAY   = 2'b00,
      ZS_RESP_SLVERR = 2'b10
   } zs_resp_e;

   // occupancy of a single-entry pipeline stage
   typedef enum logic {
      ZS_STAGE_EMPTY = 1'b0,
      ZS_STAGE_FULL  = 1'b1
   } zs_stage_e;

endpackage

`default_nettype wire

//--- include/zynq_shell_defines.svh
`ifndef ZYNQ_SHELL_DEFINES_SVH
`define ZYNQ_SHELL_DEFINES_SVH

// bus widths
`define ZS_ADDR_W        32
`define ZS_GP1_ADDR_W    30
`define ZS_DATA_W        32
`define ZS_CSR_IDX_W     3

// accelerator dram window and the usable part of it
`define ZS_DRAM_BASE     32'h8000_0000
`define ZS_MEM_LIMIT     32'h1000_0000

// accelerator host space lives below this address
`define ZS_HOST_SPLIT    32'h0020_0000

// profiler regions, index taken from addr[29 -: 7]
`define ZS_PROF_REGIONS  128
`define ZS_PROF_IDX_HI   29

// host register map
`define ZS_CSR_RESET     3'd0
`define ZS_CSR_DRAM_ALLOC 3'd1
`define ZS_CSR_DRAM_BASE 3'd2
`define ZS_CSR_RANGE_ERR 3'd3
`define ZS_CSR_PROF0     3'd4

`endif
